// File: Makefile
TOP := tb_conv1x1

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: chan_accum.sv
`timescale 1ns/1ps
`include "conv1x1_defs.svh"

module chan_accum (
  input  logic                   clk,
  input  logic                   reset,
  input  conv1x1_pkg::prod_t     prod,
  input  logic                   prod_valid,
  output logic                   prod_ready,
  output conv1x1_pkg::result_t   res,
  output logic                   res_valid,
  input  logic                   res_ready
);
  import conv1x1_pkg::*;

  logic signed [`CONV_ACC_W-1:0] acc_q;
  logic signed [`CONV_ACC_W-1:0] acc_next;
  logic                          start_q;
  oc_t                           oc_q;
  logic                          prod_fire;

  // Held result blocks new products until it leaves
  assign prod_ready = !res_valid || res_ready;
  assign prod_fire  = prod_valid && prod_ready;
  // Wrapping sum, no saturation
  assign acc_next   = start_q ? prod.data : acc_q + prod.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q   <= 1'b1;
      res_valid <= 1'b0;
    end else begin
      if (prod_fire) begin
        start_q <= prod.last;
      end
      if (prod_fire && prod.last) begin
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  // Running sum and result payload
  always_ff @(posedge clk) begin
    if (prod_fire) begin
      acc_q <= acc_next;
      oc_q  <= prod.oc;
      if (prod.last) begin
        res.data <= acc_next;
        res.oc   <= prod.oc;
      end
    end
  end

  // Every product of one sum belongs to the same output channel
  a_oc_steady : assert property (
    @(posedge clk) disable iff (reset)
    (prod_valid && !start_q) |-> (prod.oc == oc_q)
  ) else $error("chan_accum: oc changed within a sum");

endmodule

// File: chan_replay.sv
`timescale 1ns/1ps
`include "conv1x1_defs.svh"

module chan_replay (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CONV_DATA_W-1:0] pxl_data,
  input  logic                    pxl_valid,
  output logic                    pxl_ready,
  output conv1x1_pkg::tap_t       tap,
  output logic                    tap_valid,
  input  logic                    tap_ready,
  output logic                    busy
);
  import conv1x1_pkg::*;

  typedef enum logic {
    ST_COLLECT,
    ST_REPLAY
  } state_t;

  state_t                  state_q;
  ic_t                     ic_q;
  oc_t                     oc_q;
  logic [`CONV_DATA_W-1:0] chan_q [`CONV_CH_IN];
  logic                    ic_last;
  logic                    oc_last;
  logic                    pxl_fire;
  logic                    tap_fire;

  assign ic_last  = (ic_q == ic_t'(`CONV_CH_IN - 1));
  assign oc_last  = (oc_q == oc_t'(`CONV_CH_OUT - 1));
  assign pxl_fire = pxl_valid && pxl_ready;
  assign tap_fire = tap_valid && tap_ready;

  assign pxl_ready = (state_q == ST_COLLECT);
  assign tap_valid = (state_q == ST_REPLAY);
  // Partly collected pixel counts as busy too
  assign busy      = (state_q == ST_REPLAY) || (ic_q != '0);

  // Tap walks the stored channels, ic inner
  always_comb begin
    tap.data = chan_q[ic_q];
    tap.ic   = ic_q;
    tap.oc   = oc_q;
    tap.last = ic_last;
  end

  //////////////////////////////
  // Controller
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_COLLECT;
      ic_q    <= '0;
      oc_q    <= '0;
    end else begin
      case (state_q)
        ST_COLLECT: begin
          if (pxl_fire) begin
            if (ic_last) begin
              ic_q    <= '0;
              state_q <= ST_REPLAY;
            end else begin
              ic_q <= ic_q + ic_t'(1);
            end
          end
        end
        ST_REPLAY: begin
          if (tap_fire) begin
            if (ic_last) begin
              ic_q <= '0;
              // Last output channel done, back to collecting
              if (oc_last) begin
                oc_q    <= '0;
                state_q <= ST_COLLECT;
              end else begin
                oc_q <= oc_q + oc_t'(1);
              end
            end else begin
              ic_q <= ic_q + ic_t'(1);
            end
          end
        end
        default: state_q <= ST_COLLECT;
      endcase
    end
  end

  // Channel register file
  always_ff @(posedge clk) begin
    if (pxl_fire) begin
      chan_q[ic_q] <= pxl_data;
    end
  end

endmodule

// File: conv1x1_defs.svh
`ifndef CONV1X1_DEFS_SVH
`define CONV1X1_DEFS_SVH

//////////////////////////////
// Data widths
//////////////////////////////

// Pixel channel and weight width, signed fixed point
`define CONV_DATA_W 16

// Product, running sum and output width
`define CONV_ACC_W 32

//////////////////////////////
// Channel counts
//////////////////////////////

// Channels carried by each input pixel
`define CONV_CH_IN 4

// Output channels computed per pixel
`define CONV_CH_OUT 3

`endif

// File: conv1x1_layer.sv
`timescale 1ns/1ps
`include "conv1x1_defs.svh"

module conv1x1_layer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CONV_DATA_W-1:0] pxl_data,
  input  logic                    pxl_valid,
  output logic                    pxl_ready,
  input  logic [`CONV_DATA_W-1:0] wgt_data,
  input  logic                    wgt_valid,
  output conv1x1_pkg::result_t    out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);
  import conv1x1_pkg::*;

  tap_t    rep_tap;
  logic    rep_valid;
  logic    rep_ready;
  logic    busy;
  tap_t    mac_tap;
  logic    mac_valid;
  logic    mac_ready;
  prod_t   prod;
  logic    prod_valid;
  logic    prod_ready;
  result_t res;
  logic    res_valid;
  logic    res_ready;

  // Loop data, one pixel replayed per output channel
  chan_replay u_replay (
    .clk       (clk),
    .reset     (reset),
    .pxl_data  (pxl_data),
    .pxl_valid (pxl_valid),
    .pxl_ready (pxl_ready),
    .tap       (rep_tap),
    .tap_valid (rep_valid),
    .tap_ready (rep_ready),
    .busy      (busy)
  );

  pipe_slice #(.payload_t(tap_t)) u_tap_slice (
    .clk       (clk),
    .reset     (reset),
    .in_data   (rep_tap),
    .in_valid  (rep_valid),
    .in_ready  (rep_ready),
    .out_data  (mac_tap),
    .out_valid (mac_valid),
    .out_ready (mac_ready)
  );

  weight_mac u_mac (
    .clk        (clk),
    .reset      (reset),
    .wgt_data   (wgt_data),
    .wgt_valid  (wgt_valid),
    .busy       (busy),
    .tap        (mac_tap),
    .tap_valid  (mac_valid),
    .tap_ready  (mac_ready),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready)
  );

  // Sum over input channels
  chan_accum u_accum (
    .clk        (clk),
    .reset      (reset),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .res        (res),
    .res_valid  (res_valid),
    .res_ready  (res_ready)
  );

  pipe_slice #(.payload_t(result_t)) u_out_slice (
    .clk       (clk),
    .reset     (reset),
    .in_data   (res),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: conv1x1_pkg.sv
`include "conv1x1_defs.svh"

package conv1x1_pkg;

  // Index widths, never narrower than one bit
  localparam int IC_W  = (`CONV_CH_IN > 1) ? $clog2(`CONV_CH_IN) : 1;
  localparam int OC_W  = (`CONV_CH_OUT > 1) ? $clog2(`CONV_CH_OUT) : 1;
  localparam int N_WGT = `CONV_CH_OUT * `CONV_CH_IN;
  localparam int WA_W  = (N_WGT > 1) ? $clog2(N_WGT) : 1;

  typedef logic [IC_W-1:0] ic_t;
  typedef logic [OC_W-1:0] oc_t;
  typedef logic [WA_W-1:0] waddr_t;

  // One replayed channel, tagged for weight lookup
  typedef struct packed {
    logic signed [`CONV_DATA_W-1:0] data;
    ic_t                            ic;
    oc_t                            oc;
    logic                           last;
  } tap_t;

  // Product on its way to the accumulator
  typedef struct packed {
    logic signed [`CONV_ACC_W-1:0] data;
    oc_t                           oc;
    logic                          last;
  } prod_t;

  // Finished output channel value
  typedef struct packed {
    logic signed [`CONV_ACC_W-1:0] data;
    oc_t                           oc;
  } result_t;

endpackage

// File: pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  logic in_fire;

  // Free when empty or when the held beat leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Payload register, loaded only on a transfer
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_data <= in_data;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // A stalled beat must be held unchanged into the next cycle
  a_hold_stable : assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("pipe_slice: out_data changed while stalled");

endmodule

// File: tb.f
+incdir+.
conv1x1_pkg.sv
pipe_slice.sv
chan_replay.sv
weight_mac.sv
chan_accum.sv
conv1x1_layer.sv
tb_conv1x1.sv

// File: tb_conv1x1.sv
`timescale 1ns/1ps
`include "conv1x1_defs.svh"

module tb_conv1x1;
  import conv1x1_pkg::*;

  localparam int RST_CYCLES = 16;
  localparam int PIX_PER_PHASE = 8;
  localparam int N_PIX = 4 * PIX_PER_PHASE;
  localparam int CYC_LIMIT = N_PIX * `CONV_CH_OUT * `CONV_CH_IN * 4 + 400;
  localparam int SEED = 32'h6dfd_3279;

  logic                    clk = 1'b0;
  logic                    reset;
  logic [`CONV_DATA_W-1:0] pxl_data;
  logic                    pxl_valid;
  logic                    pxl_ready;
  logic [`CONV_DATA_W-1:0] wgt_data;
  logic                    wgt_valid;
  result_t                 out_data;
  logic                    out_valid;
  logic                    out_ready = 1'b1;

  // Reference model state
  logic signed [`CONV_DATA_W-1:0] wgt_m [`CONV_CH_OUT][`CONV_CH_IN];
  result_t                        exp_q [$];
  result_t                        exp_r;
  result_t                        held_q;
  logic                           stall_q = 1'b0;
  logic                           rand_ready = 1'b0;

  int cyc = 0;
  int n_checked = 0;
  int rst_errs = 0;
  int hold_errs = 0;
  int val_errs = 0;
  int oc_errs = 0;
  int flow_errs = 0;
  int total_errs;

  always #2 clk = ~clk;

  conv1x1_layer dut_i (
    .clk       (clk),
    .reset     (reset),
    .pxl_data  (pxl_data),
    .pxl_valid (pxl_valid),
    .pxl_ready (pxl_ready),
    .wgt_data  (wgt_data),
    .wgt_valid (wgt_valid),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  //////////////////////////////
  // Model and stimulus
  //////////////////////////////

  // Wrapping 32-bit sum of channel times weight
  function automatic logic signed [`CONV_ACC_W-1:0] weighted_sum(
    input int                             oc,
    input logic signed [`CONV_DATA_W-1:0] chans [`CONV_CH_IN]
  );
    logic signed [`CONV_ACC_W-1:0] acc;
    logic signed [`CONV_ACC_W-1:0] term;
    acc = '0;
    for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
      term = 32'(chans[ic]) * 32'(wgt_m[oc][ic]);
      acc  = acc + term;
    end
    return acc;
  endfunction

  // Serial load, oc major and ic minor
  task automatic load_weights();
    for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
      for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
        wgt_data      = `CONV_DATA_W'($urandom);
        wgt_m[oc][ic] = wgt_data;
        wgt_valid     = 1'b1;
        @(negedge clk);
      end
    end
    wgt_valid = 1'b0;
  endtask

  task automatic send_pixel(input bit gapped);
    logic signed [`CONV_DATA_W-1:0] chans [`CONV_CH_IN];
    result_t                        item;
    for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
      chans[ic] = `CONV_DATA_W'($urandom);
    end
    for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
      if (gapped) begin
        repeat ($urandom % 3) @(negedge clk);
      end
      pxl_data  = chans[ic];
      pxl_valid = 1'b1;
      do @(posedge clk); while (!pxl_ready);
      @(negedge clk);
      pxl_valid = 1'b0;
    end
    for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
      item.data = weighted_sum(oc, chans);
      item.oc   = oc_t'(oc);
      exp_q.push_back(item);
    end
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // Output back-pressure
  always @(negedge clk) begin
    out_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset_idle : assert property (
    @(posedge clk) (cyc >= 1 && cyc <= RST_CYCLES + 1) |-> (!out_valid && pxl_ready)
  ) else begin
    rst_errs++;
    $display("ERR %0t out_valid/pxl_ready exp 0/1 got %b/%b", $time,
             $sampled(out_valid), $sampled(pxl_ready));
  end

  // Stalled result must be offered again, unchanged
  always @(posedge clk) begin
    if (!reset && stall_q) begin
      a_out_hold : assert (out_valid && out_data == held_q) else begin
        hold_errs++;
        $display("ERR %0t out_valid/out_data exp 1/%h got %b/%h",
                 $time, held_q, out_valid, out_data);
      end
    end
    stall_q <= !reset && out_valid && !out_ready;
    held_q  <= out_data;
  end

  // Each accepted output against the head of the model queue
  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        flow_errs++;
        $display("Unexpected result at %0t with no pixel pending", $time);
      end else begin
        exp_r = exp_q.pop_front();
        n_checked++;
        a_out_value : assert (out_data.data == exp_r.data) else begin
          val_errs++;
          $display("ERR %0t out_data.data exp %h got %h", $time, exp_r.data, out_data.data);
        end
        a_out_oc : assert (out_data.oc == exp_r.oc) else begin
          oc_errs++;
          $display("ERR %0t out_data.oc exp %0d got %0d", $time, exp_r.oc, out_data.oc);
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles with %0d results pending", cyc, exp_q.size());
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    reset     = 1'b1;
    pxl_data  = '0;
    pxl_valid = 1'b0;
    wgt_data  = '0;
    wgt_valid = 1'b0;
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    // Free-running output
    load_weights();
    repeat (PIX_PER_PHASE) send_pixel(1'b0);
    drain_results();

    // Random output stalls
    rand_ready = 1'b1;
    repeat (PIX_PER_PHASE) send_pixel(1'b0);
    drain_results();
    rand_ready = 1'b0;

    // Gapped pixel stream
    repeat (PIX_PER_PHASE) send_pixel(1'b1);
    drain_results();

    // Reload while idle, address has wrapped back to zero
    load_weights();
    rand_ready = 1'b1;
    repeat (PIX_PER_PHASE) send_pixel(1'b1);
    drain_results();
    rand_ready = 1'b0;

    total_errs = rst_errs + hold_errs + val_errs + oc_errs + flow_errs;
    $display("Checked %0d results; errors reset %0d hold %0d value %0d oc %0d flow %0d",
             n_checked, rst_errs, hold_errs, val_errs, oc_errs, flow_errs);
    if (total_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: weight_mac.sv
`timescale 1ns/1ps
`include "conv1x1_defs.svh"

module weight_mac (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CONV_DATA_W-1:0] wgt_data,
  input  logic                    wgt_valid,
  input  logic                    busy,
  input  conv1x1_pkg::tap_t       tap,
  input  logic                    tap_valid,
  output logic                    tap_ready,
  output conv1x1_pkg::prod_t      prod,
  output logic                    prod_valid,
  input  logic                    prod_ready
);
  import conv1x1_pkg::*;

  logic signed [`CONV_DATA_W-1:0] wgt_q [N_WGT];
  waddr_t                         wr_addr;
  waddr_t                         rd_addr;
  logic signed [`CONV_DATA_W-1:0] wgt_rd;
  logic signed [`CONV_ACC_W-1:0]  mult;
  logic                           tap_fire;

  //////////////////////////////
  // Weight store
  //////////////////////////////

  // Serial load, oc major and ic minor, wraps to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
    end else if (wgt_valid) begin
      if (wr_addr == waddr_t'(N_WGT - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + waddr_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wgt_valid) begin
      wgt_q[wr_addr] <= wgt_data;
    end
  end

  //////////////////////////////
  // Multiply stage
  //////////////////////////////

  assign rd_addr = waddr_t'(tap.oc) * waddr_t'(`CONV_CH_IN) + waddr_t'(tap.ic);
  assign wgt_rd  = wgt_q[rd_addr];
  // Both operands signed, so the product sign-extends to full width
  assign mult    = tap.data * wgt_rd;

  assign tap_ready = !prod_valid || prod_ready;
  assign tap_fire  = tap_valid && tap_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else if (tap_ready) begin
      prod_valid <= tap_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tap_fire) begin
      prod.data <= mult;
      prod.oc   <= tap.oc;
      prod.last <= tap.last;
    end
  end

  // Weights may only be rewritten while the replay side is idle
  a_wgt_idle : assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !wgt_valid
  ) else $error("weight_mac: weight write while layer busy");

endmodule
